// File: include/ahb_periph_map.svh
// Address map of the AHB-Lite peripheral subsystem
// Slave base addresses and the size of each decoded region
`ifndef AHB_PERIPH_MAP_SVH
`define AHB_PERIPH_MAP_SVH

`define PWM_BASE    32'h0000_1000
`define GPIO_BASE   32'h0000_2000

// Each slave owns 2**REGION_BITS bytes
`define REGION_BITS 12

`endif

// File: design/ahb_periph_pkg.sv
// AHB-Lite peripheral subsystem shared definitions
// Bus request and response structs, HTRANS and HRESP codes,
// data widths and the register offsets of the PWM and GPIO slaves
package ahb_periph_pkg;

    localparam int HADDR_W    = 32;                 // Bus address width
    localparam int HDATA_W    = 32;                 // Bus data width
    localparam int REG_OFFS_W = 12;                 // Offset inside a 4 KB region

    localparam logic [1:0] HTRANS_IDLE   = 2'b00;
    localparam logic [1:0] HTRANS_NONSEQ = 2'b10;

    localparam logic HRESP_OKAY  = 1'b0;
    localparam logic HRESP_ERROR = 1'b1;

    localparam int PWM_WIDTH  = 8;                  // Counter, period and duty
    localparam int GPIO_WIDTH = 16;                 // Port pins

    localparam logic [REG_OFFS_W-1:0] PWM_CTRL    = 12'h000;    // Bit 0 enable
    localparam logic [REG_OFFS_W-1:0] PWM_PERIOD  = 12'h004;
    localparam logic [REG_OFFS_W-1:0] PWM_DUTY    = 12'h008;
    localparam logic [REG_OFFS_W-1:0] PWM_COUNT   = 12'h00C;    // Read only
    localparam logic [REG_OFFS_W-1:0] GPIO_OUT    = 12'h000;
    localparam logic [REG_OFFS_W-1:0] GPIO_IN     = 12'h004;    // Read only
    localparam logic [REG_OFFS_W-1:0] GPIO_TOGGLE = 12'h008;    // Write only, reads 0

    // Address phase of one master
    typedef struct packed {
        logic [HADDR_W-1:0] haddr;
        logic [1:0]         htrans;
        logic               hwrite;
        logic [2:0]         hsize;                  // Carried, never decoded
    } ahb_req_t;

    // Data phase response
    typedef struct packed {
        logic [HDATA_W-1:0] hrdata;
        logic               hready;
        logic               hresp;
    } ahb_rsp_t;

endpackage

// File: design/ahb_arbiter.sv
// Two-master AHB-Lite arbiter
// Round-robin grant of the shared address phase, data-phase owner
// tracking, hwdata routing and per-master response steering
`timescale 1ns/1ns

module ahb_arbiter (
    input  logic                                hclk,
    input  logic                                arst_n,
    input  ahb_periph_pkg::ahb_req_t            m0_req,
    input  ahb_periph_pkg::ahb_req_t            m1_req,
    input  logic [ahb_periph_pkg::HDATA_W-1:0]  m0_hwdata,
    input  logic [ahb_periph_pkg::HDATA_W-1:0]  m1_hwdata,
    output ahb_periph_pkg::ahb_rsp_t            m0_rsp,
    output ahb_periph_pkg::ahb_rsp_t            m1_rsp,
    output ahb_periph_pkg::ahb_req_t            bus_req,
    output logic [ahb_periph_pkg::HDATA_W-1:0]  bus_hwdata,
    input  ahb_periph_pkg::ahb_rsp_t            bus_rsp
);
    import ahb_periph_pkg::*;

    logic req0;                                     // Master 0 wants the bus
    logic req1;                                     // Master 1 wants the bus
    logic gnt;                                      // Address owner, 1 = master 1
    logic gnt_q;                                    // Owner kept across stalls
    logic last_q;                                   // Last served master
    logic dp_vld_q;                                 // Data phase in flight
    logic dp_own_q;                                 // Master owning the data phase
    logic accept;                                   // Address phase taken this edge

    // Response seen by one master
    function automatic ahb_rsp_t master_rsp(input logic own, input logic req,
                                            input logic granted, input ahb_rsp_t brsp);
        ahb_rsp_t r;
        r = '{hrdata: '0, hready: 1'b1, hresp: HRESP_OKAY};   // Idle response
        if (own)
            r = brsp;                               // Its own data phase
        else if (req)
            r.hready = granted && brsp.hready;      // Stall a waiting master
        return r;
    endfunction

    assign req0 = (m0_req.htrans == HTRANS_NONSEQ);
    assign req1 = (m1_req.htrans == HTRANS_NONSEQ);

    always_comb begin
        gnt = gnt_q;                                // Frozen while bus hready low
        if (bus_rsp.hready) begin
            if (req0 && req1)
                gnt = ~last_q;                      // Tie goes to the other one
            else if (req1)
                gnt = 1'b1;
            else if (req0)
                gnt = 1'b0;
        end
    end

    assign bus_req    = gnt ? m1_req : m0_req;
    assign bus_hwdata = dp_own_q ? m1_hwdata : m0_hwdata;
    assign accept     = (bus_req.htrans == HTRANS_NONSEQ) && bus_rsp.hready;

    always_ff @(posedge hclk or negedge arst_n) begin
        if (!arst_n) begin
            gnt_q    <= 1'b0;
            last_q   <= 1'b0;
            dp_vld_q <= 1'b0;
            dp_own_q <= 1'b0;
        end else begin
            gnt_q <= gnt;
            if (bus_rsp.hready)
                dp_vld_q <= accept;                 // Data phase ends or starts
            if (accept) begin
                last_q   <= gnt;
                dp_own_q <= gnt;
            end
        end
    end

    assign m0_rsp = master_rsp(dp_vld_q && !dp_own_q, req0, !gnt, bus_rsp);
    assign m1_rsp = master_rsp(dp_vld_q &&  dp_own_q, req1,  gnt, bus_rsp);

endmodule

// File: design/ahb_decoder.sv
// AHB-Lite address decoder
// Slave selects, data-phase response multiplexer and the
// built-in default slave answering unmapped accesses with ERROR
`timescale 1ns/1ns
`include "ahb_periph_map.svh"

module ahb_decoder (
    input  logic                        hclk,
    input  logic                        arst_n,
    input  ahb_periph_pkg::ahb_req_t    bus_req,
    output logic                        pwm_hsel,
    output logic                        gpio_hsel,
    input  ahb_periph_pkg::ahb_rsp_t    pwm_rsp,
    input  ahb_periph_pkg::ahb_rsp_t    gpio_rsp,
    output ahb_periph_pkg::ahb_rsp_t    bus_rsp
);
    import ahb_periph_pkg::*;

    typedef enum logic [2:0] {DP_NONE, DP_PWM, DP_GPIO, DP_ERR1, DP_ERR2} dp_sel_t;

    dp_sel_t dp_q;                                  // Slave owning the data phase
    dp_sel_t dp_nxt;
    logic    pwm_hit;
    logic    gpio_hit;
    logic    accept;

    // Compare the region number, upper 20 bits
    assign pwm_hit  = (bus_req.haddr >> `REGION_BITS) == (`PWM_BASE >> `REGION_BITS);
    assign gpio_hit = (bus_req.haddr >> `REGION_BITS) == (`GPIO_BASE >> `REGION_BITS);
    assign accept   = (bus_req.htrans == HTRANS_NONSEQ) && bus_rsp.hready;

    assign pwm_hsel  = pwm_hit && bus_rsp.hready;   // Only when an address can be taken
    assign gpio_hsel = gpio_hit && bus_rsp.hready;

    always_comb begin
        dp_nxt = dp_q;
        if (bus_rsp.hready) begin
            if (!accept)
                dp_nxt = DP_NONE;
            else if (pwm_hit)
                dp_nxt = DP_PWM;
            else if (gpio_hit)
                dp_nxt = DP_GPIO;
            else
                dp_nxt = DP_ERR1;                   // Unmapped, two-cycle ERROR
        end else if (dp_q == DP_ERR1) begin
            dp_nxt = DP_ERR2;
        end
    end

    always_ff @(posedge hclk or negedge arst_n) begin
        if (!arst_n)
            dp_q <= DP_NONE;
        else
            dp_q <= dp_nxt;
    end

    always_comb begin
        case (dp_q)
            DP_PWM:  bus_rsp = pwm_rsp;
            DP_GPIO: bus_rsp = gpio_rsp;
            DP_ERR1: bus_rsp = '{hrdata: '0, hready: 1'b0, hresp: HRESP_ERROR};
            DP_ERR2: bus_rsp = '{hrdata: '0, hready: 1'b1, hresp: HRESP_ERROR};
            default: bus_rsp = '{hrdata: '0, hready: 1'b1, hresp: HRESP_OKAY};
        endcase
    end

endmodule

// File: design/pwm_core.sv
// PWM timer core
// Control, period and duty registers, free running counter
// and the registered PWM output
`timescale 1ns/1ns

module pwm_core (
    input  logic                                    hclk,
    input  logic                                    arst_n,
    input  logic [ahb_periph_pkg::REG_OFFS_W-1:0]   addr,
    input  logic                                    we,
    input  logic [ahb_periph_pkg::HDATA_W-1:0]      wd,
    output logic [ahb_periph_pkg::HDATA_W-1:0]      rd,
    output logic                                    pwm
);
    import ahb_periph_pkg::*;

    logic                 en_q;                     // Timer enable
    logic [PWM_WIDTH-1:0] period_q;
    logic [PWM_WIDTH-1:0] duty_q;
    logic [PWM_WIDTH-1:0] cnt_q;                    // Position in the period

    // Register writes
    always_ff @(posedge hclk or negedge arst_n) begin
        if (!arst_n) begin
            en_q     <= 1'b0;
            period_q <= '0;
            duty_q   <= '0;
        end else if (we) begin
            case (addr)
                PWM_CTRL:   en_q     <= wd[0];
                PWM_PERIOD: period_q <= wd[PWM_WIDTH-1:0];
                PWM_DUTY:   duty_q   <= wd[PWM_WIDTH-1:0];
                default:    en_q     <= en_q;       // Count and unused are read only
            endcase
        end
    end

    always_ff @(posedge hclk or negedge arst_n) begin
        if (!arst_n) begin
            cnt_q <= '0;
            pwm   <= 1'b0;
        end else begin
            if (!en_q || (period_q == '0))
                cnt_q <= '0;                        // Stopped or zero period
            else if (cnt_q >= period_q - 1'b1)
                cnt_q <= '0;                        // Wrap at period-1
            else
                cnt_q <= cnt_q + 1'b1;
            pwm <= en_q && (cnt_q < duty_q);        // High for duty counts
        end
    end

    always_comb begin
        case (addr)
            PWM_CTRL:   rd = {{(HDATA_W-1){1'b0}}, en_q};
            PWM_PERIOD: rd = {{(HDATA_W-PWM_WIDTH){1'b0}}, period_q};
            PWM_DUTY:   rd = {{(HDATA_W-PWM_WIDTH){1'b0}}, duty_q};
            PWM_COUNT:  rd = {{(HDATA_W-PWM_WIDTH){1'b0}}, cnt_q};
            default:    rd = '0;                    // Unused offsets
        endcase
    end

endmodule

// File: design/ahb_pwm.sv
// AHB-Lite slave wrapper for the PWM timer
// Registers address and write request of an accepted transfer
// and presents a simple register port to the PWM core
`timescale 1ns/1ns

module ahb_pwm (
    input  logic                                hclk,
    input  logic                                arst_n,
    input  logic                                hsel,
    input  ahb_periph_pkg::ahb_req_t            bus_req,
    input  logic [ahb_periph_pkg::HDATA_W-1:0]  hwdata,
    output ahb_periph_pkg::ahb_rsp_t            rsp,
    output logic                                pwm
);
    import ahb_periph_pkg::*;

    logic                  pwm_request;             // Transfer aimed at this slave
    logic [REG_OFFS_W-1:0] addr_q;                  // Data-phase register offset
    logic                  we_q;                    // Data-phase write
    logic [HDATA_W-1:0]    pwm_rd;

    assign pwm_request = hsel && (bus_req.htrans == HTRANS_NONSEQ);

    always_ff @(posedge hclk) begin
        if (pwm_request)
            addr_q <= bus_req.haddr[REG_OFFS_W-1:0];
    end

    always_ff @(posedge hclk or negedge arst_n) begin
        if (!arst_n)
            we_q <= 1'b0;
        else
            we_q <= pwm_request && bus_req.hwrite;  // One data phase only
    end

    assign rsp = '{hrdata: pwm_rd, hready: 1'b1, hresp: HRESP_OKAY};   // Zero wait

    pwm_core pwm_core_i (
        .hclk   ( hclk    ),
        .arst_n ( arst_n  ),
        .addr   ( addr_q  ),                        // Register offset
        .we     ( we_q    ),                        // Write strobe
        .wd     ( hwdata  ),                        // Data-phase write data
        .rd     ( pwm_rd  ),                        // Read data
        .pwm    ( pwm     )                         // PWM output
    );

endmodule

// File: design/ahb_gpio.sv
// AHB-Lite GPIO slave
// Output register with write and toggle access,
// two-flop input synchronizer read through GPIO_IN
`timescale 1ns/1ns

module ahb_gpio (
    input  logic                                    hclk,
    input  logic                                    arst_n,
    input  logic                                    hsel,
    input  ahb_periph_pkg::ahb_req_t                bus_req,
    input  logic [ahb_periph_pkg::HDATA_W-1:0]      hwdata,
    output ahb_periph_pkg::ahb_rsp_t                rsp,
    input  logic [ahb_periph_pkg::GPIO_WIDTH-1:0]   gpio_in,
    output logic [ahb_periph_pkg::GPIO_WIDTH-1:0]   gpio_out
);
    import ahb_periph_pkg::*;

    logic                  gpio_request;
    logic [REG_OFFS_W-1:0] addr_q;                  // Data-phase offset
    logic                  we_q;
    logic [GPIO_WIDTH-1:0] sync1_q;                 // First synchronizer stage
    logic [GPIO_WIDTH-1:0] sync2_q;                 // Stable input value
    logic [HDATA_W-1:0]    rdata;

    assign gpio_request = hsel && (bus_req.htrans == HTRANS_NONSEQ);

    always_ff @(posedge hclk) begin
        if (gpio_request)
            addr_q <= bus_req.haddr[REG_OFFS_W-1:0];
    end

    always_ff @(posedge hclk or negedge arst_n) begin
        if (!arst_n) begin
            we_q     <= 1'b0;
            gpio_out <= '0;
            sync1_q  <= '0;
            sync2_q  <= '0;
        end else begin
            we_q    <= gpio_request && bus_req.hwrite;
            sync1_q <= gpio_in;
            sync2_q <= sync1_q;
            if (we_q && (addr_q == GPIO_OUT))
                gpio_out <= hwdata[GPIO_WIDTH-1:0];
            else if (we_q && (addr_q == GPIO_TOGGLE))
                gpio_out <= gpio_out ^ hwdata[GPIO_WIDTH-1:0];   // Flip set bits
        end
    end

    always_comb begin
        case (addr_q)
            GPIO_OUT: rdata = {{(HDATA_W-GPIO_WIDTH){1'b0}}, gpio_out};
            GPIO_IN:  rdata = {{(HDATA_W-GPIO_WIDTH){1'b0}}, sync2_q};
            default:  rdata = '0;                   // Toggle and unused read 0
        endcase
    end

    assign rsp = '{hrdata: rdata, hready: 1'b1, hresp: HRESP_OKAY};

endmodule

// File: design/ahb_periph_top.sv
// AHB-Lite peripheral subsystem top level
// Two masters through the arbiter, address decoder,
// PWM timer slave and GPIO slave
`timescale 1ns/1ns

module ahb_periph_top (
    input  logic                                    hclk,
    input  logic                                    arst_n,
    input  ahb_periph_pkg::ahb_req_t                m0_req,
    input  logic [ahb_periph_pkg::HDATA_W-1:0]      m0_hwdata,
    output ahb_periph_pkg::ahb_rsp_t                m0_rsp,
    input  ahb_periph_pkg::ahb_req_t                m1_req,
    input  logic [ahb_periph_pkg::HDATA_W-1:0]      m1_hwdata,
    output ahb_periph_pkg::ahb_rsp_t                m1_rsp,
    input  logic [ahb_periph_pkg::GPIO_WIDTH-1:0]   gpio_in,
    output logic [ahb_periph_pkg::GPIO_WIDTH-1:0]   gpio_out,
    output logic                                    pwm
);
    import ahb_periph_pkg::*;

    ahb_req_t           bus_req;                    // Shared address phase
    logic [HDATA_W-1:0] bus_hwdata;
    ahb_rsp_t           bus_rsp;                    // Muxed slave response
    logic               pwm_hsel;
    logic               gpio_hsel;
    ahb_rsp_t           pwm_rsp;
    ahb_rsp_t           gpio_rsp;

    ahb_arbiter ahb_arbiter_i (
        .hclk       ( hclk       ),
        .arst_n     ( arst_n     ),
        .m0_req     ( m0_req     ),
        .m1_req     ( m1_req     ),
        .m0_hwdata  ( m0_hwdata  ),
        .m1_hwdata  ( m1_hwdata  ),
        .m0_rsp     ( m0_rsp     ),
        .m1_rsp     ( m1_rsp     ),
        .bus_req    ( bus_req    ),
        .bus_hwdata ( bus_hwdata ),
        .bus_rsp    ( bus_rsp    )
    );

    ahb_decoder ahb_decoder_i (
        .hclk      ( hclk      ),
        .arst_n    ( arst_n    ),
        .bus_req   ( bus_req   ),
        .pwm_hsel  ( pwm_hsel  ),
        .gpio_hsel ( gpio_hsel ),
        .pwm_rsp   ( pwm_rsp   ),
        .gpio_rsp  ( gpio_rsp  ),
        .bus_rsp   ( bus_rsp   )
    );

    ahb_pwm ahb_pwm_i (
        .hclk    ( hclk       ),
        .arst_n  ( arst_n     ),
        .hsel    ( pwm_hsel   ),
        .bus_req ( bus_req    ),
        .hwdata  ( bus_hwdata ),
        .rsp     ( pwm_rsp    ),
        .pwm     ( pwm        )
    );

    ahb_gpio ahb_gpio_i (
        .hclk     ( hclk       ),
        .arst_n   ( arst_n     ),
        .hsel     ( gpio_hsel  ),
        .bus_req  ( bus_req    ),
        .hwdata   ( bus_hwdata ),
        .rsp      ( gpio_rsp   ),
        .gpio_in  ( gpio_in    ),
        .gpio_out ( gpio_out   )
    );

endmodule

// File: testbench/tb_ahb_periph.sv
// Testbench for the AHB-Lite peripheral subsystem
// Two master tasks, register model of the PWM and GPIO slaves,
// reset, access, contention, error, PWM output and GPIO input tests
`timescale 1ns/1ns
`include "ahb_periph_map.svh"

module tb_ahb_periph;
    import ahb_periph_pkg::*;

    localparam int PWM_ROUNDS    = 3;
    localparam int ACCESS_CYCLES = 200 * 6;                         // Accesses times cycles
    localparam int PWM_CYCLES    = PWM_ROUNDS * 2 * (4 * 255 + 10); // Sample windows
    localparam int MAX_CYCLES    = 4 * (ACCESS_CYCLES + PWM_CYCLES);

    logic                  hclk = 1'b0;
    logic                  arst_n;
    ahb_req_t              m0_req;
    ahb_req_t              m1_req;
    logic [HDATA_W-1:0]    m0_hwdata;
    logic [HDATA_W-1:0]    m1_hwdata;
    ahb_rsp_t              m0_rsp;
    ahb_rsp_t              m1_rsp;
    logic [GPIO_WIDTH-1:0] gpio_in;
    logic [GPIO_WIDTH-1:0] gpio_out;
    logic                  pwm;

    // Register model
    logic [31:0]           pwm_ctrl_m;
    logic [PWM_WIDTH-1:0]  pwm_period_m;
    logic [PWM_WIDTH-1:0]  pwm_duty_m;
    logic [GPIO_WIDTH-1:0] gpio_out_m;
    logic [GPIO_WIDTH-1:0] gpio_in_m;           // Value after the synchronizer

    int errors = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int cycles = 0;

    always #5 hclk = ~hclk;

    ahb_periph_top dut_i (
        .hclk      ( hclk      ),
        .arst_n    ( arst_n    ),
        .m0_req    ( m0_req    ),
        .m0_hwdata ( m0_hwdata ),
        .m0_rsp    ( m0_rsp    ),
        .m1_req    ( m1_req    ),
        .m1_hwdata ( m1_hwdata ),
        .m1_rsp    ( m1_rsp    ),
        .gpio_in   ( gpio_in   ),
        .gpio_out  ( gpio_out  ),
        .pwm       ( pwm       )
    );

    always @(posedge hclk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("ERROR: timeout, run did not finish within %0d cycles", MAX_CYCLES);
            $display("** FAIL **");
            $finish;
        end
    end

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("ERROR %s: got 0x%08h, expected 0x%08h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        assert (cond === 1'b1) else begin
            $display("ERROR: %s", what);
            errors++;
        end
    endtask

    task automatic drive_req(input bit m, input ahb_req_t req);
        if (m)
            m1_req = req;
        else
            m0_req = req;
    endtask

    task automatic drive_wdata(input bit m, input logic [31:0] data);
        if (m)
            m1_hwdata = data;
        else
            m0_hwdata = data;
    endtask

    function automatic ahb_rsp_t get_rsp(input bit m);
        return m ? m1_rsp : m0_rsp;
    endfunction

    // One non-pipelined transfer, sampled at the falling edge
    task automatic ahb_access(input bit m, input bit wr, input logic [31:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic resp, output int waits);
        ahb_req_t req;
        ahb_rsp_t rsp;
        req = '{haddr: addr, htrans: HTRANS_NONSEQ, hwrite: wr, hsize: 3'b010};
        waits = 0;
        @(posedge hclk);
        #1;
        drive_req(m, req);
        do begin                                // Held until the arbiter grants
            @(negedge hclk);
            rsp = get_rsp(m);
        end while (!rsp.hready);
        @(posedge hclk);
        #1;
        req.htrans = HTRANS_IDLE;
        drive_req(m, req);
        drive_wdata(m, wdata);                  // Data phase
        @(negedge hclk);
        rsp = get_rsp(m);
        while (!rsp.hready) begin
            waits++;
            @(negedge hclk);
            rsp = get_rsp(m);
        end
        rdata = rsp.hrdata;
        resp  = rsp.hresp;
    endtask

    task automatic ahb_write(input bit m, input logic [31:0] addr, input logic [31:0] data,
                             output logic resp);
        logic [31:0] rd;
        int          waits;
        ahb_access(m, 1'b1, addr, data, rd, resp, waits);
        check_eq("hresp", resp, HRESP_OKAY);
        check_eq("data phase waits", waits, 0);
    endtask

    task automatic ahb_read(input bit m, input logic [31:0] addr, output logic [31:0] data,
                            output logic resp);
        int waits;
        ahb_access(m, 1'b0, addr, 32'h0, data, resp, waits);
        check_eq("hresp", resp, HRESP_OKAY);
        check_eq("data phase waits", waits, 0);
    endtask

    function automatic logic [31:0] pwm_expected(input logic [11:0] offs);
        case (offs)
            PWM_CTRL:   return {31'h0, pwm_ctrl_m[0]};
            PWM_PERIOD: return {24'h0, pwm_period_m};
            PWM_DUTY:   return {24'h0, pwm_duty_m};
            default:    return 32'h0;
        endcase
    endfunction

    function automatic logic [31:0] gpio_expected(input logic [11:0] offs);
        case (offs)
            GPIO_OUT: return {16'h0, gpio_out_m};
            GPIO_IN:  return {16'h0, gpio_in_m};
            default:  return 32'h0;             // Toggle reads zero
        endcase
    endfunction

    task automatic pwm_model_write(input logic [11:0] offs, input logic [31:0] data);
        case (offs)
            PWM_CTRL:   pwm_ctrl_m   = data;
            PWM_PERIOD: pwm_period_m = data[PWM_WIDTH-1:0];
            PWM_DUTY:   pwm_duty_m   = data[PWM_WIDTH-1:0];
            default:    ;
        endcase
    endtask

    task automatic pwm_random_access(input bit m);
        logic [11:0] offs;
        logic [31:0] data;
        logic        resp;
        offs = 12'(4 * $urandom_range(0, 2));
        data = $urandom;
        if ($urandom_range(0, 1)) begin
            ahb_write(m, `PWM_BASE + offs, data, resp);
            pwm_model_write(offs, data);
        end else begin
            ahb_read(m, `PWM_BASE + offs, data, resp);
            check_eq("pwm hrdata", data, pwm_expected(offs));
        end
    endtask

    task automatic gpio_random_access(input bit m);
        logic [11:0] offs;
        logic [31:0] data;
        logic        resp;
        offs = 12'(4 * $urandom_range(0, 2));
        data = $urandom;
        if ($urandom_range(0, 1) && offs != GPIO_IN) begin
            ahb_write(m, `GPIO_BASE + offs, data, resp);
            if (offs == GPIO_OUT)
                gpio_out_m = data[GPIO_WIDTH-1:0];
            else
                gpio_out_m ^= data[GPIO_WIDTH-1:0];     // Toggle
        end else begin
            ahb_read(m, `GPIO_BASE + offs, data, resp);
            check_eq("gpio hrdata", data, gpio_expected(offs));
        end
    endtask

    task automatic end_test(input string name, input int errs_at_start);
        tests_run++;
        if (errors != errs_at_start)
            tests_failed++;
        $display("test %0d %s: %s", tests_run, name, (errors == errs_at_start) ? "ok" : "failed");
    endtask

    initial begin
        logic [31:0] addr;
        logic [31:0] data;
        logic        resp;
        int          waits;
        int          start;
        int          high;
        int          period;
        void'($urandom(32'h21b));
        arst_n    = 1'b0;
        m0_req    = '{haddr: '0, htrans: HTRANS_IDLE, hwrite: 1'b0, hsize: 3'b010};
        m1_req    = '{haddr: '0, htrans: HTRANS_IDLE, hwrite: 1'b0, hsize: 3'b010};
        m0_hwdata = '0;
        m1_hwdata = '0;
        gpio_in   = '0;
        pwm_ctrl_m = '0;
        pwm_period_m = '0;
        pwm_duty_m = '0;
        gpio_out_m = '0;
        gpio_in_m  = '0;
        repeat (2) @(posedge hclk);
        #1;
        arst_n = 1'b1;

        // Reset values through both masters
        start = errors;
        check_true(m0_rsp.hready && m1_rsp.hready, "master hready low after reset");
        for (int m = 0; m < 2; m++) begin
            for (int i = 0; i < 4; i++) begin
                ahb_read(m[0], `PWM_BASE + 4 * i, data, resp);
                check_eq("pwm reset hrdata", data, 32'h0);
            end
            for (int i = 0; i < 3; i++) begin
                ahb_read(m[0], `GPIO_BASE + 4 * i, data, resp);
                check_eq("gpio reset hrdata", data, 32'h0);
            end
        end
        check_eq("pwm", pwm, 1'b0);
        check_eq("gpio_out", gpio_out, 32'h0);
        end_test("reset values", start);

        // Directed register writes and read-back
        start = errors;
        for (int m = 0; m < 2; m++) begin
            for (int r = 0; r < 3; r++) begin
                for (int i = 0; i < 3; i++) begin
                    data = $urandom;
                    ahb_write(m[0], `PWM_BASE + 4 * i, data, resp);
                    pwm_model_write(12'(4 * i), data);
                end
                for (int i = 0; i < 3; i++) begin
                    ahb_read(m[0], `PWM_BASE + 4 * i, data, resp);
                    check_eq("pwm hrdata", data, pwm_expected(12'(4 * i)));
                end
                data = $urandom;
                ahb_write(m[0], `GPIO_BASE + GPIO_OUT, data, resp);
                gpio_out_m = data[GPIO_WIDTH-1:0];
                data = $urandom;
                ahb_write(m[0], `GPIO_BASE + GPIO_TOGGLE, data, resp);
                gpio_out_m ^= data[GPIO_WIDTH-1:0];
                ahb_read(m[0], `GPIO_BASE + GPIO_OUT, data, resp);
                check_eq("gpio hrdata", data, gpio_expected(GPIO_OUT));
                ahb_read(m[0], `GPIO_BASE + GPIO_TOGGLE, data, resp);
                check_eq("gpio toggle hrdata", data, 32'h0);
                check_eq("gpio_out", gpio_out, gpio_out_m);
            end
        end
        end_test("register access", start);

        // Both masters at once, PWM on master 0 and GPIO on master 1
        start = errors;
        fork
            repeat (50) pwm_random_access(1'b0);
            repeat (50) gpio_random_access(1'b1);
        join
        for (int i = 0; i < 3; i++) begin
            ahb_read(1'b1, `PWM_BASE + 4 * i, data, resp);
            check_eq("pwm final hrdata", data, pwm_expected(12'(4 * i)));
        end
        ahb_read(1'b0, `GPIO_BASE + GPIO_OUT, data, resp);
        check_eq("gpio final hrdata", data, gpio_expected(GPIO_OUT));
        check_eq("gpio_out", gpio_out, gpio_out_m);
        end_test("contention", start);

        // Unmapped addresses get a two-cycle ERROR
        start = errors;
        for (int i = 0; i < 10; i++) begin
            do begin
                addr = $urandom & 32'hffff_fffc;
            end while ((addr >> `REGION_BITS) == (`PWM_BASE >> `REGION_BITS) ||
                       (addr >> `REGION_BITS) == (`GPIO_BASE >> `REGION_BITS));
            ahb_access(i[0], i[1], addr, $urandom, data, resp, waits);
            check_eq("error hresp", resp, HRESP_ERROR);
            check_eq("error hready low cycles", waits, 1);
            data = $urandom;
            ahb_write(i[0], `GPIO_BASE + GPIO_OUT, data, resp);
            gpio_out_m = data[GPIO_WIDTH-1:0];
            ahb_read(~i[0], `GPIO_BASE + GPIO_OUT, data, resp);
            check_eq("gpio hrdata", data, gpio_expected(GPIO_OUT));
        end
        end_test("error response", start);

        // PWM output over whole periods, enabled then disabled
        start = errors;
        for (int r = 0; r < PWM_ROUNDS; r++) begin
            period = $urandom_range(1, 255);
            data   = $urandom;
            ahb_write(1'b0, `PWM_BASE + PWM_CTRL, 32'h0, resp);
            ahb_write(1'b0, `PWM_BASE + PWM_PERIOD, period, resp);
            ahb_write(1'b0, `PWM_BASE + PWM_DUTY, data, resp);
            pwm_duty_m   = data[PWM_WIDTH-1:0];
            pwm_period_m = period[PWM_WIDTH-1:0];
            ahb_read(1'b0, `PWM_BASE + PWM_DUTY, data, resp);
            check_eq("pwm duty hrdata", data, pwm_expected(PWM_DUTY));
            ahb_read(1'b1, `PWM_BASE + PWM_COUNT, data, resp);
            check_eq("pwm count stopped", data, 32'h0);
            ahb_write(1'b1, `PWM_BASE + PWM_CTRL, 32'h1, resp);
            repeat (3) @(posedge hclk);
            high = 0;
            repeat (4 * period) begin
                @(negedge hclk);
                high += pwm;
            end
            check_eq("pwm high cycles", high,
                     4 * ((pwm_duty_m < period) ? pwm_duty_m : period));
            ahb_write(1'b0, `PWM_BASE + PWM_CTRL, 32'h0, resp);
            repeat (3) @(posedge hclk);
            high = 0;
            repeat (4 * period) begin
                @(negedge hclk);
                high += pwm;
            end
            check_eq("pwm high cycles disabled", high, 0);
        end
        pwm_ctrl_m = '0;
        end_test("pwm output", start);

        // Input through the two-flop synchronizer
        start = errors;
        @(posedge hclk);
        #1;
        gpio_in   = $urandom;
        gpio_in_m = gpio_in;
        repeat (3) @(posedge hclk);
        ahb_read(1'b1, `GPIO_BASE + GPIO_IN, data, resp);
        check_eq("gpio_in hrdata", data, gpio_expected(GPIO_IN));
        end_test("gpio input", start);

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

// File: flist.f
+incdir+include
design/ahb_periph_pkg.sv
design/ahb_arbiter.sv
design/ahb_decoder.sv
design/pwm_core.sv
design/ahb_pwm.sv
design/ahb_gpio.sv
design/ahb_periph_top.sv
testbench/tb_ahb_periph.sv
